// ==== design/riscv_ctrl_pkg.sv ====
/*
 * RV64I multicycle control package.
 * State, instruction class, trap cause and datapath select encodings,
 * plus the packed structs carried between the control blocks.
 */
package riscv_ctrl_pkg;

    // ------------------------------------------------------------------------
    // state and decode encodings
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        FETCH, DECODE, MEMADDR, MEMREAD, MEMWB, MEMWRITE, EXECUTER,
        EXECUTEI, ALUWB, JAL, BRANCH, LOADI, TRAP
    } t_state;

    typedef enum logic [3:0] {
        LOAD, OP_IMM, JALR, OP_IMM_W, STORE, OP, OP_W,
        BRANCH_C, JAL_C, AUIPC, LUI, SYSTEM, ILLEGAL
    } t_instr_class;

    typedef enum logic [1:0] {NONE, ECALL, EBREAK, MRET} t_sys_kind;

    // major opcodes, bits [6:0].
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_W     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // ------------------------------------------------------------------------
    // datapath selects
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, ALU_BRANCH = 3'd1, ALU_FUNC = 3'd2, ALU_FUNC_W = 3'd3
    } t_alu_op;

    typedef enum logic [2:0] {
        RES_ALU_OUT  = 3'd0, RES_MEM_DATA = 3'd1, RES_ALU_RESULT = 3'd2,
        RES_IMM      = 3'd3, RES_CSR_DATA = 3'd4, RES_OLD_PC     = 3'd6,
        RES_TRAP_VEC = 3'd7
    } t_result_src;

    typedef logic [1:0] t_alu_src;
    localparam t_alu_src SRC1_PC     = 2'd0;
    localparam t_alu_src SRC1_OLD_PC = 2'd1;
    localparam t_alu_src SRC1_REG    = 2'd2;
    localparam t_alu_src SRC2_REG    = 2'd0;
    localparam t_alu_src SRC2_IMM    = 2'd1;
    localparam t_alu_src SRC2_FOUR   = 2'd2;

    typedef enum logic [2:0] {
        CSR_MTVEC = 3'd3, CSR_MCAUSE = 3'd4, CSR_MEPC = 3'd5
    } t_csr_addr;

    // mcause codes, software interrupt and breakpoint share 3.
    typedef logic [3:0] t_cause;
    localparam t_cause CAUSE_INSTR_MA = 4'd0;
    localparam t_cause CAUSE_ILLEGAL  = 4'd2;
    localparam t_cause CAUSE_BREAK    = 4'd3;
    localparam t_cause CAUSE_LOAD_MA  = 4'd4;
    localparam t_cause CAUSE_STORE_MA = 4'd6;
    localparam t_cause CAUSE_ECALL_M  = 4'd11;
    localparam t_cause CAUSE_M_SOFT   = 4'd3;
    localparam t_cause CAUSE_M_TIMER  = 4'd7;

    // ------------------------------------------------------------------------
    // grouped inputs and outputs
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] op;
        logic [2:0] funct3;
        logic       funct7_4;
        logic       instr_20;
    } t_instr_fields;

    typedef struct packed {
        logic stall_instr;
        logic stall_data;
        logic icache_idle;
        logic instr_addr_ma;
        logic load_addr_ma;
        logic store_addr_ma;
        logic illegal_load;
    } t_mem_status;

    typedef struct packed {
        logic timer;
        logic software;
    } t_irq;

    typedef struct packed {
        t_alu_op     alu_op;
        t_result_src result_src;
        t_alu_src    alu_src_1;
        t_alu_src    alu_src_2;
        logic        reg_write_en;
        logic        pc_update;
        logic        instr_write_en;
        logic        branch;
        logic        mem_reg_we;
        logic        reg_mem_addr_we;
        logic        fetch_state;
    } t_dp_ctrl;

    typedef struct packed {
        logic start_i_cache;
        logic start_d_cache;
        logic mem_write_en;
    } t_mem_ctrl;

    typedef struct packed {
        logic      we_1;
        logic      we_2;
        t_csr_addr write_addr_1;
        t_csr_addr write_addr_2;
        t_csr_addr read_addr;
        t_cause    mcause;
        logic      interrupt;
        logic      mret;
    } t_csr_ctrl;

endpackage

// ==== design/instr_decoder.sv ====
/*
 * Instruction decoder.
 * Maps the major opcode to an instruction class and splits SYSTEM
 * into ecall, ebreak and mret.
 */
`timescale 1ns/100ps

module instr_decoder
    import riscv_ctrl_pkg::*;
(
    input  t_instr_fields i_fields,
    output t_instr_class  o_class,
    output t_sys_kind     o_sys_kind
);

    logic sys_priv; // funct3 zero, privileged encodings only.

    assign sys_priv = (i_fields.funct3 == 3'b000);

    always_comb begin
        case (i_fields.op)
            OPC_LOAD:     o_class = LOAD;
            OPC_OP_IMM:   o_class = OP_IMM;
            OPC_JALR:     o_class = JALR;
            OPC_OP_IMM_W: o_class = OP_IMM_W;
            OPC_STORE:    o_class = STORE;
            OPC_OP:       o_class = OP;
            OPC_OP_W:     o_class = OP_W;
            OPC_BRANCH:   o_class = BRANCH_C;
            OPC_JAL:      o_class = JAL_C;
            OPC_AUIPC:    o_class = AUIPC;
            OPC_LUI:      o_class = LUI;
            // csr access instructions are not supported.
            OPC_SYSTEM:   o_class = sys_priv ? SYSTEM : ILLEGAL;
            default:      o_class = ILLEGAL;
        endcase
    end

    // sub-kind only means something when the class is SYSTEM.
    always_comb begin
        o_sys_kind = NONE;
        if (i_fields.op == OPC_SYSTEM && sys_priv) begin
            if (i_fields.funct7_4) begin
                o_sys_kind = MRET;
            end else if (i_fields.instr_20) begin
                o_sys_kind = EBREAK;
            end else begin
                o_sys_kind = ECALL;
            end
        end
    end

endmodule

// ==== design/trap_ctrl.sv ====
/*
 * Machine-mode trap unit.
 * Decides trap entry in the current state, picks the mcause code and
 * drives the mcause, mepc and mtvec accesses.
 */
`timescale 1ns/100ps

module trap_ctrl
    import riscv_ctrl_pkg::*;
(
    input  t_state       i_state,
    input  t_instr_class i_class,
    input  t_sys_kind    i_sys_kind,
    input  t_mem_status  i_mem,
    input  t_irq         i_irq,
    output logic         o_trap_take,
    output t_csr_ctrl    o_csr
);

    logic   irq_pend;
    logic   trap;
    logic   is_irq;
    logic   mret;
    t_cause cause;

    // interrupts only land between fetches.
    assign irq_pend = i_mem.icache_idle & (i_irq.timer | i_irq.software);

    always_comb begin
        trap   = 1'b0;
        is_irq = 1'b0;
        mret   = 1'b0;
        cause  = '0;
        case (i_state)
            FETCH: begin
                if (irq_pend) begin
                    trap   = 1'b1;
                    is_irq = 1'b1;
                    cause  = i_irq.timer ? CAUSE_M_TIMER : CAUSE_M_SOFT; // timer first.
                end else if (i_mem.instr_addr_ma) begin
                    trap  = 1'b1;
                    cause = CAUSE_INSTR_MA;
                end
            end
            DECODE: begin
                if (i_class == ILLEGAL) begin
                    trap  = 1'b1;
                    cause = CAUSE_ILLEGAL;
                end else if (i_class == SYSTEM) begin
                    case (i_sys_kind)
                        ECALL:   begin trap = 1'b1; cause = CAUSE_ECALL_M; end
                        EBREAK:  begin trap = 1'b1; cause = CAUSE_BREAK; end
                        MRET:    mret = 1'b1;
                        default: mret = 1'b0;
                    endcase
                end
            end
            MEMREAD: begin
                if (i_mem.illegal_load) begin
                    trap  = 1'b1;
                    cause = CAUSE_ILLEGAL;
                end else if (i_mem.load_addr_ma) begin
                    trap  = 1'b1;
                    cause = CAUSE_LOAD_MA;
                end
            end
            MEMWRITE: begin
                trap  = i_mem.store_addr_ma;
                cause = CAUSE_STORE_MA;
            end
            default: trap = 1'b0;
        endcase
    end

    assign o_trap_take = trap;

    // mcause and mepc are written in the entry cycle.
    assign o_csr.we_1         = trap;
    assign o_csr.we_2         = trap;
    assign o_csr.write_addr_1 = CSR_MCAUSE;
    assign o_csr.write_addr_2 = CSR_MEPC;
    assign o_csr.read_addr    = (i_state == JAL) ? CSR_MEPC : CSR_MTVEC; // mret target.
    assign o_csr.mcause       = trap ? cause : '0;
    assign o_csr.interrupt    = is_irq;
    assign o_csr.mret         = mret;

endmodule

// ==== design/control_fsm.sv ====
/*
 * Control sequencer.
 * State register and next-state logic of the multicycle core.
 */
`timescale 1ns/100ps

module control_fsm
    import riscv_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         arst,
    input  t_instr_class i_class,
    input  t_sys_kind    i_sys_kind,
    input  t_mem_status  i_mem,
    input  logic         i_trap_take,
    output t_state       o_state
);

    t_state state;
    t_state next_state;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            FETCH: begin
                if (i_trap_take)            next_state = TRAP;
                else if (!i_mem.stall_instr) next_state = DECODE;
            end
            DECODE: begin
                if (i_trap_take) begin
                    next_state = TRAP;
                end else begin
                    case (i_class)
                        LOAD, STORE, JALR:  next_state = MEMADDR;
                        OP_IMM, OP_IMM_W:   next_state = EXECUTEI;
                        OP, OP_W:           next_state = EXECUTER;
                        BRANCH_C:           next_state = BRANCH;
                        JAL_C:              next_state = JAL;
                        AUIPC:              next_state = ALUWB; // sum formed in decode.
                        LUI:                next_state = LOADI;
                        SYSTEM:             next_state = (i_sys_kind == MRET) ? JAL : FETCH;
                        default:            next_state = FETCH;
                    endcase
                end
            end
            MEMADDR: begin
                case (i_class)
                    LOAD:    next_state = MEMREAD;
                    STORE:   next_state = MEMWRITE;
                    JALR:    next_state = JAL;
                    default: next_state = FETCH;
                endcase
            end
            MEMREAD: begin
                if (i_trap_take)            next_state = TRAP;
                else if (!i_mem.stall_data) next_state = MEMWB;
            end
            MEMWRITE: begin
                if (i_trap_take)            next_state = TRAP;
                else if (!i_mem.stall_data) next_state = FETCH;
            end
            EXECUTER, EXECUTEI: next_state = ALUWB;
            // mret jumps and is done, jal/jalr still write the link.
            JAL:     next_state = (i_class == SYSTEM) ? FETCH : ALUWB;
            MEMWB, ALUWB, BRANCH, LOADI, TRAP: next_state = FETCH;
            default: next_state = FETCH;
        endcase
    end

    assign o_state = state;

endmodule

// ==== design/datapath_ctrl.sv ====
/*
 * Datapath control table.
 * Per-state ALU selects, result source, register and PC enables and
 * the cache start strobes, with stall and trap overrides.
 */
`timescale 1ns/100ps

module datapath_ctrl
    import riscv_ctrl_pkg::*;
(
    input  t_state       i_state,
    input  t_instr_class i_class,
    input  t_mem_status  i_mem,
    input  logic         i_trap_take,
    output t_dp_ctrl     o_dp,
    output t_mem_ctrl    o_mem
);

    t_dp_ctrl  dp;
    t_mem_ctrl mem;

    always_comb begin
        dp            = '0;
        dp.alu_op     = ALU_ADD;
        dp.result_src = RES_ALU_OUT;
        dp.alu_src_1  = SRC1_PC;
        dp.alu_src_2  = SRC2_REG;
        mem           = '0;

        case (i_state)
            FETCH: begin
                dp.result_src     = RES_ALU_RESULT; // pc + 4.
                dp.alu_src_2      = SRC2_FOUR;
                dp.fetch_state    = 1'b1;
                dp.instr_write_en = !i_mem.stall_instr;
                dp.pc_update      = !i_mem.stall_instr;
                mem.start_i_cache = 1'b1;
            end
            DECODE: begin
                // branch and jump target, old pc + imm.
                dp.alu_src_1 = SRC1_OLD_PC;
                dp.alu_src_2 = SRC2_IMM;
            end
            MEMADDR: begin
                dp.alu_src_1       = SRC1_REG;
                dp.alu_src_2       = SRC2_IMM;
                dp.result_src      = RES_ALU_RESULT;
                dp.reg_mem_addr_we = 1'b1;
            end
            MEMREAD: begin
                dp.alu_src_1      = SRC1_REG;
                dp.alu_src_2      = SRC2_IMM;
                dp.mem_reg_we     = !i_mem.stall_data;
                mem.start_d_cache = 1'b1;
            end
            MEMWB: begin
                dp.result_src   = RES_MEM_DATA;
                dp.reg_write_en = 1'b1;
            end
            MEMWRITE: begin
                dp.alu_src_1      = SRC1_REG;
                dp.alu_src_2      = SRC2_IMM;
                dp.mem_reg_we     = !i_mem.stall_data;
                mem.start_d_cache = 1'b1;
                mem.mem_write_en  = !i_mem.stall_data;
            end
            EXECUTER: begin
                dp.alu_src_1 = SRC1_REG;
                dp.alu_src_2 = SRC2_REG;
                dp.alu_op    = (i_class == OP_W) ? ALU_FUNC_W : ALU_FUNC;
            end
            EXECUTEI: begin
                dp.alu_src_1 = SRC1_REG;
                dp.alu_src_2 = SRC2_IMM;
                dp.alu_op    = (i_class == OP_IMM_W) ? ALU_FUNC_W : ALU_FUNC;
            end
            ALUWB: dp.reg_write_en = 1'b1;
            JAL: begin
                // link value old pc + 4, target from alu out or mepc.
                dp.alu_src_1  = SRC1_OLD_PC;
                dp.alu_src_2  = SRC2_FOUR;
                dp.pc_update  = 1'b1;
                dp.result_src = (i_class == SYSTEM) ? RES_CSR_DATA : RES_ALU_OUT;
            end
            BRANCH: begin
                dp.alu_src_1 = SRC1_REG;
                dp.alu_src_2 = SRC2_REG;
                dp.alu_op    = ALU_BRANCH;
                dp.branch    = 1'b1;
            end
            LOADI: begin
                dp.result_src   = RES_IMM;
                dp.reg_write_en = 1'b1;
            end
            TRAP: begin
                dp.result_src = RES_TRAP_VEC; // mtvec.
                dp.pc_update  = 1'b1;
            end
            default: dp.fetch_state = 1'b0;
        endcase

        // trap entry, old pc goes to mepc and nothing else commits.
        if (i_trap_take) begin
            dp.result_src     = RES_OLD_PC;
            dp.pc_update      = 1'b0;
            dp.instr_write_en = 1'b0;
            dp.mem_reg_we     = 1'b0;
            mem               = '0;
        end
    end

    assign o_dp  = dp;
    assign o_mem = mem;

endmodule

// ==== design/riscv_control.sv ====
/*
 * RV64I multicycle control unit, top level.
 * Connects the decoder, trap unit, sequencer and datapath control table.
 */
`timescale 1ns/100ps

module riscv_control
    import riscv_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          arst,
    input  t_instr_fields i_fields,
    input  t_mem_status   i_mem,
    input  t_irq          i_irq,
    output t_dp_ctrl      o_dp,
    output t_mem_ctrl     o_mem,
    output t_csr_ctrl     o_csr
);

    t_instr_class instr_class;
    t_sys_kind    sys_kind;
    t_state       state;
    logic         trap_take;

    instr_decoder u_decoder (
        .i_fields   (i_fields),
        .o_class    (instr_class),
        .o_sys_kind (sys_kind)
    );

    trap_ctrl u_trap (
        .i_state     (state),
        .i_class     (instr_class),
        .i_sys_kind  (sys_kind),
        .i_mem       (i_mem),
        .i_irq       (i_irq),
        .o_trap_take (trap_take),
        .o_csr       (o_csr)
    );

    control_fsm u_fsm (
        .clk         (clk),
        .arst        (arst),
        .i_class     (instr_class),
        .i_sys_kind  (sys_kind),
        .i_mem       (i_mem),
        .i_trap_take (trap_take),
        .o_state     (state)
    );

    datapath_ctrl u_dp (
        .i_state     (state),
        .i_class     (instr_class),
        .i_mem       (i_mem),
        .i_trap_take (trap_take),
        .o_dp        (o_dp),
        .o_mem       (o_mem)
    );

endmodule

// ==== dv/riscv_control_sva.sv ====
/*
 * Control unit checker, bound to the top level.
 * Write enable exclusion, CSR writes against PC updates and the
 * maximum gap between fetches.
 */
`timescale 1ns/100ps

module riscv_control_sva
    import riscv_ctrl_pkg::*;
(
    input logic        clk,
    input logic        arst,
    input t_mem_status i_mem_status,
    input t_dp_ctrl    i_dp,
    input t_mem_ctrl   i_mem_ctrl,
    input t_csr_ctrl   i_csr
);

    logic [3:0] gap_cnt; // cycles since the last fetch, stalls not counted.

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            gap_cnt <= '0;
        end else if (i_dp.fetch_state) begin
            gap_cnt <= '0;
        end else if (!i_mem_status.stall_instr && !i_mem_status.stall_data) begin
            gap_cnt <= gap_cnt + 4'd1;
        end
    end

    // ------------------------------------------------------------------------
    // properties
    // ------------------------------------------------------------------------
    a_no_dual_write: assert property (@(posedge clk) disable iff (arst)
        !(i_mem_ctrl.mem_write_en && i_dp.reg_write_en))
        else $error("memory and register write enables high together");

    a_we1_no_pc: assert property (@(posedge clk) disable iff (arst)
        i_csr.we_1 |-> !i_dp.pc_update)
        else $error("csr write port 1 active with pc update");

    a_we2_no_pc: assert property (@(posedge clk) disable iff (arst)
        i_csr.we_2 |-> !i_dp.pc_update)
        else $error("csr write port 2 active with pc update");

    a_fetch_gap: assert property (@(posedge clk) disable iff (arst)
        gap_cnt < 4'd12)
        else $error("no fetch within 12 cycles");

endmodule

bind riscv_control riscv_control_sva u_sva (
    .clk          (clk),
    .arst         (arst),
    .i_mem_status (i_mem),
    .i_dp         (o_dp),
    .i_mem_ctrl   (o_mem),
    .i_csr        (o_csr)
);

// ==== dv/riscv_control_tb.sv ====
/*
 * Testbench for the RV64I control unit.
 * Runs a table of instructions, stalls and trap conditions and checks
 * cycle counts, write enables, CSR accesses and mcause codes.
 */
`timescale 1ns/100ps

module riscv_control_tb
    import riscv_ctrl_pkg::*;
;

    typedef struct {
        string         name;
        t_instr_fields fields;
        logic [4:0]    flags; // icache_idle, instr_ma, load_ma, store_ma, illegal_load.
        t_irq          irq;
        int            stall_kind; // 0 none, 1 fetch, 2 data.
        int            cycles;
        logic          trap;
        t_cause        cause;
        logic          regw;
        logic [2:0]    src;
        logic          memw;
        logic          mret;
    } t_row;

    logic          clk = 1'b0;
    logic          arst;
    t_instr_fields i_fields;
    t_mem_status   i_mem;
    t_irq          i_irq;
    t_dp_ctrl      o_dp;
    t_mem_ctrl     o_mem;
    t_csr_ctrl     o_csr;

    t_row        rows[$];
    logic [31:0] lfsr = 32'd93079;
    logic        table_ready = 1'b0;
    string       cur_name;
    int          err_count = 0;
    int          row_errs;
    int          failed_tests = 0;

    riscv_control uut (.*);

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // galois step.
    endtask

    task automatic check_cond(input logic ok, input string what);
        assert (ok) else begin
            $display("FAILED %0t ns: %s, %s", $time, cur_name, what);
            err_count++;
            row_errs++;
        end
    endtask

    // cause or src below zero means no trap or no register write.
    task automatic add_row(input string name, input t_instr_fields f, input logic [4:0] flags,
                           input t_irq irq, input int stall_kind, input int cycles,
                           input int cause, input int src, input logic memw,
                           input logic mret);
        t_row r;
        r = '{name, f, flags, irq, stall_kind, cycles, cause >= 0, 4'(cause),
              src >= 0, 3'(src), memw, mret};
        rows.push_back(r);
    endtask

    task automatic build_table();
        //      name        fields                flags     irq    stl cyc cause src memw mret
        add_row("op",       {OPC_OP, 5'b0},       5'b0,     2'b00, 0, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("op_w",     {OPC_OP_W, 5'b0},     5'b0,     2'b00, 0, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("op_imm",   {OPC_OP_IMM, 5'b0},   5'b0,     2'b00, 0, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("op_imm_w", {OPC_OP_IMM_W, 5'b0}, 5'b0,     2'b00, 0, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("load",     {OPC_LOAD, 5'b0},     5'b0,     2'b00, 0, 5, -1, RES_MEM_DATA, 1'b0, 1'b0);
        add_row("store",    {OPC_STORE, 5'b0},    5'b0,     2'b00, 0, 4, -1, -1, 1'b1, 1'b0);
        add_row("branch",   {OPC_BRANCH, 5'b0},   5'b0,     2'b00, 0, 3, -1, -1, 1'b0, 1'b0);
        add_row("jal",      {OPC_JAL, 5'b0},      5'b0,     2'b00, 0, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("jalr",     {OPC_JALR, 5'b0},     5'b0,     2'b00, 0, 5, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("lui",      {OPC_LUI, 5'b0},      5'b0,     2'b00, 0, 3, -1, RES_IMM, 1'b0, 1'b0);
        add_row("auipc",    {OPC_AUIPC, 5'b0},    5'b0,     2'b00, 0, 3, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("mret",     {OPC_SYSTEM, 3'd0, 2'b10}, 5'b0, 2'b00, 0, 3, -1, -1, 1'b0, 1'b1);
        add_row("op_fstl",  {OPC_OP, 5'b0},       5'b0,     2'b00, 1, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("opi_fstl", {OPC_OP_IMM, 5'b0},   5'b0,     2'b00, 1, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("ld_dstl",  {OPC_LOAD, 5'b0},     5'b0,     2'b00, 2, 5, -1, RES_MEM_DATA, 1'b0, 1'b0);
        add_row("st_dstl",  {OPC_STORE, 5'b0},    5'b0,     2'b00, 2, 4, -1, -1, 1'b1, 1'b0);
        add_row("illegal",  {7'h00, 5'b0},        5'b0,     2'b00, 0, 3, 2, -1, 1'b0, 1'b0);
        add_row("csr_op",   {OPC_SYSTEM, 3'd1, 2'b00}, 5'b0, 2'b00, 0, 3, 2, -1, 1'b0, 1'b0);
        add_row("ecall",    {OPC_SYSTEM, 5'b0},   5'b0,     2'b00, 0, 3, 11, -1, 1'b0, 1'b0);
        add_row("ebreak",   {OPC_SYSTEM, 3'd0, 2'b01}, 5'b0, 2'b00, 0, 3, 3, -1, 1'b0, 1'b0);
        add_row("ld_ma",    {OPC_LOAD, 5'b0},     5'b00100, 2'b00, 0, 5, 4, -1, 1'b0, 1'b0);
        add_row("ld_ill",   {OPC_LOAD, 5'b0},     5'b00101, 2'b00, 0, 5, 2, -1, 1'b0, 1'b0);
        add_row("st_ma",    {OPC_STORE, 5'b0},    5'b00010, 2'b00, 0, 5, 6, -1, 1'b0, 1'b0);
        add_row("irq_busy", {OPC_OP, 5'b0},       5'b00000, 2'b10, 0, 4, -1, RES_ALU_OUT, 1'b0, 1'b0);
        add_row("timer",    {OPC_OP, 5'b0},       5'b10000, 2'b10, 0, 2, 7, -1, 1'b0, 1'b0);
        add_row("soft",     {OPC_OP, 5'b0},       5'b10000, 2'b01, 0, 2, 3, -1, 1'b0, 1'b0);
        add_row("tmr_soft", {OPC_OP, 5'b0},       5'b10000, 2'b11, 0, 2, 7, -1, 1'b0, 1'b0);
        add_row("soft_ima", {OPC_OP, 5'b0},       5'b11000, 2'b01, 0, 2, 3, -1, 1'b0, 1'b0);
        add_row("instr_ma", {OPC_OP, 5'b0},       5'b11000, 2'b00, 0, 2, 0, -1, 1'b0, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // outputs while reset is held
    // ------------------------------------------------------------------------
    task automatic check_reset();
        cur_name = "reset";
        row_errs = 0;
        check_cond(o_dp.fetch_state && o_mem.start_i_cache, "fetch outputs in reset");
        check_cond(!o_mem.start_d_cache, "data cache strobe in reset");
        check_cond(!o_dp.reg_write_en && !o_mem.mem_write_en, "write enables in reset");
        check_cond(!o_csr.we_1 && !o_csr.we_2 && !o_csr.mret, "csr controls in reset");
        if (row_errs != 0) failed_tests++;
        $display("test %-9s %s", cur_name, (row_errs == 0) ? "ok" : "bad");
    endtask

    // ------------------------------------------------------------------------
    // one instruction, from its fetch to the next fetch
    // ------------------------------------------------------------------------
    task automatic run_row(input t_row r);
        int   cyc;
        int   stall_len;
        int   left;
        int   regw_n;
        int   memw_n;
        int   we_n;
        int   mret_n;
        logic b0;
        logic b1;
        logic left_fetch;
        logic after_we;
        logic after_mret;
        logic exp_irq;
        logic done;

        cur_name   = r.name;
        row_errs   = 0;
        stall_len  = 0;
        if (r.stall_kind != 0) begin
            take_bit(b0);
            take_bit(b1);
            stall_len = {30'd0, b1, b0};
        end
        left       = stall_len;
        exp_irq    = r.flags[4] & (r.irq.timer | r.irq.software); // idle and pending.
        {cyc, regw_n, memw_n, we_n, mret_n} = '0;
        {left_fetch, after_we, after_mret, done} = '0;
        while (!done) begin
            i_fields = r.fields;
            i_irq    = r.irq;
            i_mem    = {2'b00, r.flags};
            i_mem.stall_instr = (r.stall_kind == 1) && (left > 0);
            i_mem.stall_data  = (r.stall_kind == 2) && (left > 0);
            #2;
            cyc++;
            if ((i_mem.stall_instr && o_dp.fetch_state) ||
                (i_mem.stall_data && o_mem.start_d_cache)) begin
                check_cond(!o_dp.instr_write_en && !o_dp.pc_update && !o_dp.mem_reg_we
                           && !o_mem.mem_write_en, "commit during stall");
                left--;
            end
            if (after_we) begin
                check_cond(o_csr.read_addr == CSR_MTVEC, "trap cycle csr read");
                check_cond(o_dp.pc_update && o_dp.result_src == RES_TRAP_VEC, "trap jump");
            end
            if (after_mret) begin
                check_cond(o_csr.read_addr == CSR_MEPC, "mret csr read");
                check_cond(o_dp.pc_update && o_dp.result_src == RES_CSR_DATA, "mret jump");
            end
            after_we   = o_csr.we_1;
            after_mret = o_csr.mret;
            if (o_csr.we_1) begin
                we_n++;
                check_cond(o_csr.we_2, "mepc write enable");
                check_cond(o_csr.write_addr_1 == CSR_MCAUSE, "mcause address");
                check_cond(o_csr.write_addr_2 == CSR_MEPC, "mepc address");
                check_cond(o_csr.mcause == r.cause, "mcause value");
                check_cond(o_csr.interrupt == exp_irq, "interrupt flag");
                check_cond(o_dp.result_src == RES_OLD_PC, "trap result source");
            end
            if (o_dp.reg_write_en) begin
                regw_n++;
                check_cond(o_dp.result_src == r.src, "writeback result source");
            end
            if (o_mem.mem_write_en) memw_n++;
            if (o_csr.mret) mret_n++;
            if (!o_dp.fetch_state) left_fetch = 1'b1;
            @(negedge clk);
            done = (o_dp.fetch_state && left_fetch) || (cyc >= 16);
        end
        check_cond(cyc == r.cycles + stall_len, "cycle count");
        check_cond(regw_n == (r.regw ? 1 : 0), "register write count");
        check_cond(memw_n == (r.memw ? 1 : 0), "memory write count");
        check_cond(we_n == (r.trap ? 1 : 0), "csr write count");
        check_cond(mret_n == (r.mret ? 1 : 0), "mret count");
        if (row_errs != 0) failed_tests++;
        $display("test %-9s %s  cycles %0d  stall %0d", r.name,
                 (row_errs == 0) ? "ok" : "bad", cyc, stall_len);
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        arst     = 1'b1;
        i_fields = '0;
        i_mem    = '0;
        i_irq    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(negedge clk);
        check_reset();
        arst = 1'b0; // fsm sits in fetch from here.
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("tests %0d, failed tests %0d, failed checks %0d", rows.size() + 1,
                 failed_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((16 + 20 * rows.size()) * 8);
        $display("timeout: the test table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== riscv_control.f ====
design/riscv_ctrl_pkg.sv
design/instr_decoder.sv
design/trap_ctrl.sv
design/control_fsm.sv
design/datapath_ctrl.sv
design/riscv_control.sv
dv/riscv_control_sva.sv
dv/riscv_control_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV64I control unit testbench.

TOP   = riscv_control_tb
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f riscv_control.f --Mdir $(BUILD)

run: compile
	$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
